// ==== isa_pkg.sv ====
package isa_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths of the architectural state and the instruction fields
	//////////////////////////////////////////////////////////////////////

	localparam int DATA_W    = 32;
	localparam int REG_IDX_W = 3;
	localparam int IMM_W     = 8;
	localparam int OPCODE_W  = 3;

	// One register per index value, r0 included
	localparam int NUM_REGS  = 1 << REG_IDX_W;

	// Register contents and ALU results
	typedef logic [DATA_W-1:0] data_t;

	// Register file address
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Immediate as it sits in the instruction word
	typedef logic signed [IMM_W-1:0] imm_t;

	//////////////////////////////////////////////////////////////////////
	// Operations
	//////////////////////////////////////////////////////////////////////

	// OP_ADDI takes the immediate as operand B
	// OP_LI returns the immediate and ignores operand A
	typedef enum logic [OPCODE_W-1:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_ADDI = 3'd5,
		OP_LI   = 3'd6
	} opcode_e;

	// 20-bit instruction word, opcode in the top bits
	typedef struct packed {
		opcode_e  opcode;
		reg_idx_t rd;
		reg_idx_t ra;
		reg_idx_t rb;
		imm_t     imm;
	} instr_t;

	// Immediates are always sign-extended to a full data word
	function automatic data_t sext_imm(imm_t imm);
		return {{(DATA_W - IMM_W){imm[IMM_W-1]}}, imm};
	endfunction

endpackage

// ==== pipe_pkg.sv ====
package pipe_pkg;

	//////////////////////////////////////////////////////////////////////
	// Operand lanes between decode and execute
	//////////////////////////////////////////////////////////////////////

	// Two source operands per instruction
	localparam int NUM_OPERANDS = 2;

	// Lane index of each operand
	localparam int OPND_A = 0;
	localparam int OPND_B = 1;

	// Width of an operand source select
	localparam int SEL_W = 2;

	// Where an operand comes from
	typedef enum logic [SEL_W-1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} opnd_sel_e;

	//////////////////////////////////////////////////////////////////////
	// Stage payloads
	//////////////////////////////////////////////////////////////////////

	// Control of 7 bits handed from decode to EX
	// valid low means EX takes a bubble
	typedef struct packed {
		logic              valid;
		isa_pkg::opcode_e  opcode;
		isa_pkg::reg_idx_t rd;
	} ex_ctrl_t;

	// WB result of 35 bits that is also the output channel payload
	typedef struct packed {
		isa_pkg::reg_idx_t rd;
		isa_pkg::data_t    data;
	} result_t;

endpackage

// ==== reg_file.sv ====
module reg_file (
	input  logic              clk,
	input  logic              rst_n,
	input  isa_pkg::reg_idx_t rd_idx_a,
	input  isa_pkg::reg_idx_t rd_idx_b,
	output isa_pkg::data_t    rd_data_a,
	output isa_pkg::data_t    rd_data_b,
	input  logic              wr_en,
	input  isa_pkg::reg_idx_t wr_idx,
	input  isa_pkg::data_t    wr_data
);
	import isa_pkg::*;

	// Register storage
	data_t regs [NUM_REGS];

	//////////////////////////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////////////////////////

	// Both ports are combinational
	// r0 is hardwired to zero whatever the array holds
	assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
	assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

	//////////////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////////////

	// Single synchronous write, driven by the WB handshake
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Execute filters r0 destinations before they reach the write port
	a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> wr_idx != '0);

endmodule

// ==== decode_stage.sv ====
module decode_stage (
	input  logic                clk,
	input  logic                rst_n,
	// Instruction channel, four-phase
	input  logic                in_req,
	input  isa_pkg::instr_t     in_instr,
	output logic                in_ack,
	// Stall handshake with EX
	input  logic                ex_freeze,
	output logic                id_freeze,
	// Destinations still in flight
	input  logic                ex_rd_valid,
	input  isa_pkg::reg_idx_t   ex_rd,
	input  logic                wb_busy,
	input  isa_pkg::reg_idx_t   wb_rd,
	// Operand sources
	output isa_pkg::reg_idx_t   rf_idx_a,
	output isa_pkg::reg_idx_t   rf_idx_b,
	output isa_pkg::data_t      imm_ext,
	output pipe_pkg::opnd_sel_e sel [pipe_pkg::NUM_OPERANDS],
	output pipe_pkg::ex_ctrl_t  ctrl
);
	import isa_pkg::*;
	import pipe_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		HOLD,
		WAIT_REQ_LOW
	} id_state_e;

	id_state_e state;
	instr_t    held;
	logic      capture;
	logic      use_imm;

	//////////////////////////////////////////////////////////////////////
	// Input handshake and instruction hold
	//////////////////////////////////////////////////////////////////////

	// Take a new instruction only when EX can move this cycle
	assign capture = (state == IDLE) && in_req && !ex_freeze;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= IDLE;
			in_ack <= 1'b0;
			held   <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (capture) begin
						held  <= in_instr;
						state <= HOLD;
					end
				end
				HOLD: begin
					// Ack goes up one cycle after capture
					in_ack <= 1'b1;
					// Release into EX on the first unfrozen edge
					if (!ex_freeze) begin
						state <= WAIT_REQ_LOW;
					end
				end
				WAIT_REQ_LOW: begin
					// Ack follows req down, then the channel is free
					if (in_ack && !in_req) begin
						in_ack <= 1'b0;
						state  <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// No instruction for EX unless one is held
	// Low on the capture edge too, so a parked operand latch is cleared
	// before the held instruction loads its operands
	assign id_freeze = !((state == HOLD) || capture);

	// Bubble whenever the held slot is empty
	assign ctrl.valid  = (state == HOLD);
	assign ctrl.opcode = held.opcode;
	assign ctrl.rd     = held.rd;

	//////////////////////////////////////////////////////////////////////
	// Operand sources and forwarding
	//////////////////////////////////////////////////////////////////////

	assign rf_idx_a = held.ra;
	assign rf_idx_b = held.rb;
	assign imm_ext  = sext_imm(held.imm);

	// Operand B is the immediate for these two
	assign use_imm = (held.opcode == OP_ADDI) || (held.opcode == OP_LI);

	// Newest producer wins: EX, then WB, then the register file
	always_comb begin
		reg_idx_t src;
		for (int lane = 0; lane < NUM_OPERANDS; lane++) begin
			src = (lane == OPND_A) ? held.ra : held.rb;
			if (lane == OPND_B && use_imm) begin
				sel[lane] = SEL_IMM;
			end else if (src == '0) begin
				// r0 reads zero from the file, never forwarded
				sel[lane] = SEL_RF;
			end else if (ex_rd_valid && ex_rd == src) begin
				sel[lane] = SEL_EX_FORW;
			end else if (wb_busy && wb_rd == src) begin
				sel[lane] = SEL_WB_FORW;
			end else begin
				sel[lane] = SEL_RF;
			end
		end
	end

	// Ack answers a live request from the producer
	a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(in_ack) |-> in_req);

endmodule

// ==== operand_latch.sv ====
module operand_latch (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                id_freeze,
	input  logic                ex_freeze,
	input  pipe_pkg::opnd_sel_e sel,
	input  isa_pkg::data_t      rf_data,
	input  isa_pkg::data_t      imm_ext,
	input  isa_pkg::data_t      ex_forw,
	input  isa_pkg::data_t      wb_forw,
	output isa_pkg::data_t      muxed,
	output isa_pkg::data_t      operand
);
	import pipe_pkg::*;

	// Set while the latch is parked on a value taken during an ID bubble
	logic saved;

	//////////////////////////////////////////////////////////////////////
	// Source selector
	//////////////////////////////////////////////////////////////////////

	// Lane A never sees SEL_IMM and shares the same mux
	always_comb begin
		case (sel)
			SEL_IMM: muxed = imm_ext;
			SEL_EX_FORW: muxed = ex_forw;
			SEL_WB_FORW: muxed = wb_forw;
			default: muxed = rf_data;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// ID/EX operand register
	//////////////////////////////////////////////////////////////////////

	// Load when EX advances with nothing saved and park if ID is frozen
	// Saved value stays until both stages move again
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			operand <= '0;
			saved   <= 1'b0;
		end else if (!ex_freeze && !saved) begin
			operand <= muxed;
			saved   <= id_freeze;
		end else if (!ex_freeze && !id_freeze) begin
			saved <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// A parked latch keeps both its value and its flag through any stall
	a_saved_hold: assert property (@(posedge clk) disable iff (!rst_n)
		saved && (ex_freeze || id_freeze) |=> saved && $stable(operand));

	// An issue-cycle load never takes an unknown source value
	a_known_load: assert property (@(posedge clk) disable iff (!rst_n)
		!ex_freeze && !saved && !id_freeze |-> !$isunknown(muxed));

endmodule

// ==== exec_stage.sv ====
module exec_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  pipe_pkg::ex_ctrl_t ctrl,
	input  isa_pkg::data_t     operand_a,
	input  isa_pkg::data_t     operand_b,
	// Forwarding and hazard view for decode
	output isa_pkg::data_t     ex_forw,
	output logic               ex_rd_valid,
	output isa_pkg::reg_idx_t  ex_rd,
	output logic               wb_busy,
	output isa_pkg::reg_idx_t  wb_rd,
	output isa_pkg::data_t     wb_forw,
	output logic               ex_freeze,
	// Result channel, four-phase
	output logic               out_req,
	input  logic               out_ack,
	output pipe_pkg::result_t  out_result,
	// Write-back into the register file
	output logic               rf_wr_en,
	output isa_pkg::reg_idx_t  rf_wr_idx,
	output isa_pkg::data_t     rf_wr_data
);
	import isa_pkg::*;
	import pipe_pkg::*;

	typedef enum logic [1:0] {
		EMPTY,
		REQ,
		WAIT_ACK_LOW
	} wb_state_e;

	ex_ctrl_t  ex_ctrl;
	data_t     alu_res;
	wb_state_e wb_state;
	result_t   wb_q;
	logic      wb_load;

	//////////////////////////////////////////////////////////////////////
	// EX stage
	//////////////////////////////////////////////////////////////////////

	// EX waits while its instruction cannot drain into WB
	assign ex_freeze = ex_ctrl.valid && (wb_state != EMPTY);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_ctrl <= '0;
		end else if (!ex_freeze) begin
			ex_ctrl <= ctrl;
		end
	end

	// ALU, operand B already holds the immediate for ADDI and LI
	always_comb begin
		case (ex_ctrl.opcode)
			OP_ADD, OP_ADDI: alu_res = operand_a + operand_b;
			OP_SUB: alu_res = operand_a - operand_b;
			OP_AND: alu_res = operand_a & operand_b;
			OP_OR: alu_res = operand_a | operand_b;
			OP_XOR: alu_res = operand_a ^ operand_b;
			OP_LI: alu_res = operand_b;
			default: alu_res = '0;
		endcase
	end

	assign ex_forw     = alu_res;
	assign ex_rd_valid = ex_ctrl.valid;
	assign ex_rd       = ex_ctrl.rd;

	//////////////////////////////////////////////////////////////////////
	// WB stage and output handshake
	//////////////////////////////////////////////////////////////////////

	// Move a valid result into an empty WB slot
	assign wb_load = (wb_state == EMPTY) && ex_ctrl.valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_state <= EMPTY;
		end else begin
			case (wb_state)
				EMPTY: begin
					if (wb_load) begin
						wb_state <= REQ;
					end
				end
				REQ: begin
					// Result commits on this edge, req drops
					if (out_ack) begin
						wb_state <= WAIT_ACK_LOW;
					end
				end
				WAIT_ACK_LOW: begin
					if (!out_ack) begin
						wb_state <= EMPTY;
					end
				end
				default: begin
					wb_state <= EMPTY;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wb_load) begin
			wb_q.rd   <= ex_ctrl.rd;
			wb_q.data <= alu_res;
		end
	end

	assign out_req    = (wb_state == REQ);
	assign out_result = wb_q;

	// Slot stays occupied until the consumer lets go of ack
	assign wb_busy = (wb_state != EMPTY);
	assign wb_rd   = wb_q.rd;
	assign wb_forw = wb_q.data;

	// Commit on the ack edge; r0 results are reported but never stored
	assign rf_wr_en   = (wb_state == REQ) && out_ack && (wb_q.rd != '0);
	assign rf_wr_idx  = wb_q.rd;
	assign rf_wr_data = wb_q.data;

	// Payload is held for the whole request phase
	a_result_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_req |=> !out_req || $stable(out_result));

endmodule

// ==== int_pipe_top.sv ====
module int_pipe_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_req,
	input  isa_pkg::instr_t   in_instr,
	output logic              in_ack,
	output logic              out_req,
	input  logic              out_ack,
	output pipe_pkg::result_t out_result
);
	import isa_pkg::*;
	import pipe_pkg::*;

	// Stall signals
	logic      id_freeze;
	logic      ex_freeze;

	// Hazard view of the stages behind decode
	logic      ex_rd_valid;
	reg_idx_t  ex_rd;
	logic      wb_busy;
	reg_idx_t  wb_rd;

	// Register file ports
	reg_idx_t  rf_idx_a;
	reg_idx_t  rf_idx_b;
	logic      rf_wr_en;
	reg_idx_t  rf_wr_idx;
	data_t     rf_wr_data;

	// Per-lane operand traffic
	data_t     rf_data [NUM_OPERANDS];
	opnd_sel_e sel [NUM_OPERANDS];
	data_t     operand [NUM_OPERANDS];
	data_t     imm_ext;
	data_t     ex_forw;
	data_t     wb_forw;
	ex_ctrl_t  ctrl;

	reg_file i_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_idx_a  (rf_idx_a),
		.rd_idx_b  (rf_idx_b),
		.rd_data_a (rf_data[OPND_A]),
		.rd_data_b (rf_data[OPND_B]),
		.wr_en     (rf_wr_en),
		.wr_idx    (rf_wr_idx),
		.wr_data   (rf_wr_data)
	);

	decode_stage i_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_req      (in_req),
		.in_instr    (in_instr),
		.in_ack      (in_ack),
		.ex_freeze   (ex_freeze),
		.id_freeze   (id_freeze),
		.ex_rd_valid (ex_rd_valid),
		.ex_rd       (ex_rd),
		.wb_busy     (wb_busy),
		.wb_rd       (wb_rd),
		.rf_idx_a    (rf_idx_a),
		.rf_idx_b    (rf_idx_b),
		.imm_ext     (imm_ext),
		.sel         (sel),
		.ctrl        (ctrl)
	);

	// One identical latch per operand lane
	// The pre-register mux value is only needed inside the latch
	for (genvar lane = 0; lane < NUM_OPERANDS; lane++) begin : g_lane
		operand_latch i_latch (
			.clk       (clk),
			.rst_n     (rst_n),
			.id_freeze (id_freeze),
			.ex_freeze (ex_freeze),
			.sel       (sel[lane]),
			.rf_data   (rf_data[lane]),
			.imm_ext   (imm_ext),
			.ex_forw   (ex_forw),
			.wb_forw   (wb_forw),
			.muxed     (),
			.operand   (operand[lane])
		);
	end

	exec_stage i_exec (
		.clk         (clk),
		.rst_n       (rst_n),
		.ctrl        (ctrl),
		.operand_a   (operand[OPND_A]),
		.operand_b   (operand[OPND_B]),
		.ex_forw     (ex_forw),
		.ex_rd_valid (ex_rd_valid),
		.ex_rd       (ex_rd),
		.wb_busy     (wb_busy),
		.wb_rd       (wb_rd),
		.wb_forw     (wb_forw),
		.ex_freeze   (ex_freeze),
		.out_req     (out_req),
		.out_ack     (out_ack),
		.out_result  (out_result),
		.rf_wr_en    (rf_wr_en),
		.rf_wr_idx   (rf_wr_idx),
		.rf_wr_data  (rf_wr_data)
	);

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
	output logic clk
);
	// Full clock period in time units
	localparam int PERIOD = 20;

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

endmodule

// ==== tb_int_pipe_tasks.svh ====
`ifndef TB_INT_PIPE_TASKS_SVH
`define TB_INT_PIPE_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// Checks
//////////////////////////////////////////////////////////////////////

// Single compare point for every value check
task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] expected);
	if (got !== expected) begin
		$display("CHECK FAILED at time %0t: %s is %0h, expected %0h",
			$time, what, got, expected);
		finish_failed();
	end
endtask

//////////////////////////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////////////////////////

// Result of one instruction against the model's register state
function automatic data_t predict_result(instr_t ins);
	data_t a;
	data_t b;
	data_t imm_ext;
	// Immediate is sign-extended from bit 7
	imm_ext = {{24{ins.imm[7]}}, ins.imm};
	a = model_regs[ins.ra];
	b = model_regs[ins.rb];
	case (ins.opcode)
		OP_ADD: return a + b;
		OP_SUB: return a - b;
		OP_AND: return a & b;
		OP_OR: return a | b;
		OP_XOR: return a ^ b;
		OP_ADDI: return a + imm_ext;
		OP_LI: return imm_ext;
		default: return '0;
	endcase
endfunction

// Queue the expected result, then commit it in issue order
// r0 results are still reported but never stored
task automatic record_expected(input instr_t ins);
	result_t res;
	res.rd   = ins.rd;
	res.data = predict_result(ins);
	exp_q.push_back(res);
	if (ins.rd != '0) begin
		model_regs[ins.rd] = res.data;
	end
endtask

//////////////////////////////////////////////////////////////////////
// Stimulus helpers
//////////////////////////////////////////////////////////////////////

function automatic instr_t encode_instr(opcode_e op, reg_idx_t rd, reg_idx_t ra,
		reg_idx_t rb, imm_t imm);
	instr_t ins;
	ins.opcode = op;
	ins.rd     = rd;
	ins.ra     = ra;
	ins.rb     = rb;
	ins.imm    = imm;
	return ins;
endfunction

// One full four-phase transfer started on a rising edge
task automatic send_instr(input instr_t ins);
	record_expected(ins);
	n_issued++;
	in_req   <= 1'b1;
	in_instr <= ins;
	do @(posedge clk); while (!in_ack);
	in_req <= 1'b0;
	// Channel is free again once ack is low
	do @(posedge clk); while (in_ack);
endtask

// Wait until every issued result is received and the output channel is idle
task automatic wait_drain();
	while (exp_q.size() != 0 || out_req || out_ack) begin
		@(posedge clk);
	end
endtask

`endif

// ==== tb_int_pipe.sv ====
module tb_int_pipe;
	import isa_pkg::*;
	import pipe_pkg::*;

	// Upper bound on the directed sections
	localparam int MAX_DIRECTED     = 32;
	localparam int NUM_RANDOM       = 300;
	// Worst case per instruction at the longest ack delay
	localparam int CYCLES_PER_INSTR = 20;
	localparam int TIMEOUT_CYCLES   = (MAX_DIRECTED + NUM_RANDOM) * CYCLES_PER_INSTR;

	logic    clk;
	logic    rst_n;
	logic    in_req;
	instr_t  in_instr;
	logic    in_ack;
	logic    out_req;
	logic    out_ack;
	result_t out_result;

	// Model registers and results still to come
	data_t   model_regs [NUM_REGS];
	result_t exp_q [$];
	int      n_issued;
	int      n_results;
	int      cycle_count;

	// Ack delay range of the current section, in cycles
	int      ack_min;
	int      ack_max;

	task automatic finish_failed();
		$display("sim failed");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		finish_failed();
	endtask

	`include "tb_int_pipe_tasks.svh"

	tb_clock_gen i_clk_gen (
		.clk (clk)
	);

	int_pipe_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_req     (in_req),
		.in_instr   (in_instr),
		.in_ack     (in_ack),
		.out_req    (out_req),
		.out_ack    (out_ack),
		.out_result (out_result)
	);

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		void'($urandom(74227));
		rst_n     <= 1'b0;
		in_req    <= 1'b0;
		in_instr  <= '0;
		n_issued  = 0;
		n_results = 0;
		ack_min   = 0;
		ack_max   = 0;
		for (int i = 0; i < NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// Handshakes idle out of reset
		@(posedge clk);
		check_value("in_ack after reset", in_ack, 0);
		check_value("out_req after reset", out_req, 0);

		// Dependent chain, ack at once
		send_instr(encode_instr(OP_LI, 3'd1, 3'd0, 3'd0, 8'sd5));
		send_instr(encode_instr(OP_ADD, 3'd2, 3'd1, 3'd1, 8'sd0));
		send_instr(encode_instr(OP_SUB, 3'd3, 3'd2, 3'd1, 8'sd0));
		send_instr(encode_instr(OP_XOR, 3'd4, 3'd3, 3'd2, 8'sd0));
		send_instr(encode_instr(OP_AND, 3'd5, 3'd4, 3'd3, 8'sd0));
		send_instr(encode_instr(OP_OR, 3'd6, 3'd5, 3'd4, 8'sd0));
		send_instr(encode_instr(OP_ADD, 3'd7, 3'd6, 3'd6, 8'sd0));
		wait_drain();

		// Long acks keep producers parked in WB at distance 1 and 2
		ack_min = 6;
		ack_max = 10;
		send_instr(encode_instr(OP_ADDI, 3'd1, 3'd1, 3'd0, 8'sd3));
		send_instr(encode_instr(OP_ADDI, 3'd2, 3'd2, 3'd0, -8'sd2));
		send_instr(encode_instr(OP_ADD, 3'd3, 3'd1, 3'd2, 8'sd0));
		send_instr(encode_instr(OP_LI, 3'd4, 3'd0, 3'd0, 8'sd127));
		send_instr(encode_instr(OP_ADD, 3'd5, 3'd3, 3'd4, 8'sd0));
		send_instr(encode_instr(OP_SUB, 3'd6, 3'd4, 3'd5, 8'sd0));
		send_instr(encode_instr(OP_XOR, 3'd1, 3'd6, 3'd5, 8'sd0));
		wait_drain();

		// Sign extension at both ends of the range
		ack_min = 0;
		ack_max = 3;
		send_instr(encode_instr(OP_LI, 3'd1, 3'd0, 3'd0, -8'sd128));
		send_instr(encode_instr(OP_LI, 3'd2, 3'd0, 3'd0, 8'sd127));
		send_instr(encode_instr(OP_ADDI, 3'd3, 3'd2, 3'd0, -8'sd1));
		send_instr(encode_instr(OP_ADDI, 3'd4, 3'd1, 3'd0, -8'sd1));
		send_instr(encode_instr(OP_ADDI, 3'd5, 3'd0, 3'd0, -8'sd1));
		wait_drain();

		// r0 result shows on the channel but reads stay zero
		ack_max = 2;
		send_instr(encode_instr(OP_LI, 3'd0, 3'd0, 3'd0, 8'sd85));
		send_instr(encode_instr(OP_ADD, 3'd1, 3'd0, 3'd0, 8'sd0));
		send_instr(encode_instr(OP_ADDI, 3'd2, 3'd0, 3'd0, 8'sd9));
		send_instr(encode_instr(OP_OR, 3'd3, 3'd0, 3'd2, 8'sd0));
		wait_drain();

		// Random mix
		ack_max = 5;
		for (int n = 0; n < NUM_RANDOM; n++) begin
			send_instr(encode_instr(opcode_e'($urandom_range(6, 0)),
				reg_idx_t'($urandom_range(7, 0)), reg_idx_t'($urandom_range(7, 0)),
				reg_idx_t'($urandom_range(7, 0)), imm_t'($urandom_range(255, 0))));
		end
		wait_drain();

		if (n_results == n_issued && exp_q.size() == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("Received %0d results for %0d issued instructions",
				n_results, n_issued);
			finish_failed();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output consumer and result checks
	//////////////////////////////////////////////////////////////////////

	initial begin : result_monitor
		int      delay;
		result_t expected;
		out_ack <= 1'b0;
		forever begin
			@(posedge clk);
			if (out_req) begin
				delay = $urandom_range(ack_max, ack_min);
				repeat (delay) @(posedge clk);
				if (exp_q.size() == 0) begin
					stop_run("A result arrived with no instruction outstanding");
				end
				expected = exp_q.pop_front();
				check_value("result rd", out_result.rd, expected.rd);
				check_value("result data", out_result.data, expected.data);
				n_results++;
				out_ack <= 1'b1;
				// Req drops on the commit edge
				do @(posedge clk); while (out_req);
				out_ack <= 1'b0;
			end
		end
	end

	// Bounded run time
	initial begin : watchdog
		cycle_count = 0;
		forever begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count >= TIMEOUT_CYCLES) begin
				$display("Timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
				finish_failed();
			end
		end
	end

endmodule

// ==== sim.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
reg_file.sv
decode_stage.sv
operand_latch.sv
exec_stage.sv
int_pipe_top.sv
tb_clock_gen.sv
tb_int_pipe.sv

// ==== Bender.yml ====
package:
  name: int_pipe

sources:
  # Design sources, packages first
  - target: any(rtl, test)
    files:
      - isa_pkg.sv
      - pipe_pkg.sv
      - reg_file.sv
      - decode_stage.sv
      - operand_latch.sv
      - exec_stage.sv
      - int_pipe_top.sv

  # Testbench
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_int_pipe.sv
